// File: all.f
verilog/ap_pkg.sv
verilog/ap_reg_decode.sv
verilog/ap_xfer_fsm.sv
verilog/ap_addr_regs.sv
verilog/ap_read_mux.sv
verilog/ap_mem_access_port.sv
tb/ap_properties.sv
tb/ap_checker.sv
tb/ap_tb.sv

// File: tb/ap_checker.sv
/*
 * Response checker
 * Watches the DUT ports and compares them with the expected values
 */
`timescale 1ns/100ps

module ap_checker (
  input  logic            dclk,
  input  logic            apreset_n,
  input  logic [8*16-1:0] test_name_i,
  input  logic [31:0]     exp_rdata_i,
  input  logic            exp_err_i,
  input  logic [31:0]     exp_addr_i,
  input  logic [1:0]      exp_size_i,
  input  logic            exp_write_i,
  input  logic            exp_bus_i,
  input  logic            chk_rdata_i,
  input  logic            dp_req_i,
  input  logic            ap_ack_i,
  input  logic            ap_wr_en_i,
  input  logic [31:0]     ap_rdata_i,
  input  logic            ap_err_i,
  input  logic [31:0]     slv_addr_i,
  input  logic [1:0]      slv_size_i,
  input  logic            slv_write_i,
  input  logic [1:0]      slv_trans_i,
  input  logic            slv_ready_i,
  output integer          err_cnt_o,
  output integer          chk_cnt_o
);

  integer wait_cnt;
  integer strobe_cnt;
  integer addr_cnt;
  integer lat;
  logic   ack_q;
  logic   late_seen;

  initial begin
    err_cnt_o  = 0;
    chk_cnt_o  = 0;
    wait_cnt   = 0;
    strobe_cnt = 0;
    addr_cnt   = 0;
    ack_q      = 1'b0;
    late_seen  = 1'b0;
  end

  always @(posedge dclk) begin
    if (apreset_n) begin
      if (dp_req_i != ap_ack_i) begin
        wait_cnt = wait_cnt + 1;
      end
      // ----------------------------------------------------------
      // Data return strobe
      // ----------------------------------------------------------
      if (ap_wr_en_i) begin
        strobe_cnt = strobe_cnt + 1;
        chk_cnt_o  = chk_cnt_o + 1;
        if (ap_err_i !== exp_err_i) begin
          $display("mismatch %0s err expected %0d actual %0d",
                   test_name_i, exp_err_i, ap_err_i);
          err_cnt_o = err_cnt_o + 1;
        end
        if (chk_rdata_i && ap_rdata_i !== exp_rdata_i) begin
          $display("mismatch %0s rdata expected %h actual %h",
                   test_name_i, exp_rdata_i, ap_rdata_i);
          err_cnt_o = err_cnt_o + 1;
        end
      end
      // Address phase, compared in its final cycle
      if (slv_trans_i == 2'b10 && slv_ready_i) begin
        addr_cnt  = addr_cnt + 1;
        chk_cnt_o = chk_cnt_o + 1;
        if (!exp_bus_i) begin
          $display("test %0s started a bus transfer it should not have", test_name_i);
          err_cnt_o = err_cnt_o + 1;
        end else if (slv_addr_i !== exp_addr_i || slv_size_i !== exp_size_i ||
                     slv_write_i !== exp_write_i) begin
          $display("mismatch %0s addr/size/write expected %h/%0d/%0d actual %h/%0d/%0d",
                   test_name_i, exp_addr_i, exp_size_i, exp_write_i,
                   slv_addr_i, slv_size_i, slv_write_i);
          err_cnt_o = err_cnt_o + 1;
        end
      end
      // ----------------------------------------------------------
      // Request closed by the acknowledge toggle
      // ----------------------------------------------------------
      if (ap_ack_i != ack_q) begin
        lat = wait_cnt;
        chk_cnt_o = chk_cnt_o + 1;
        if (exp_bus_i && (lat < 4 || addr_cnt != 1)) begin
          $display("test %0s took %0d cycles with %0d address phases, expected one bus transfer",
                   test_name_i, lat, addr_cnt);
          err_cnt_o = err_cnt_o + 1;
        end
        if (!exp_bus_i && lat != 2) begin
          $display("test %0s was acknowledged after %0d cycles instead of 2",
                   test_name_i, lat);
          err_cnt_o = err_cnt_o + 1;
        end
        if (strobe_cnt != 1) begin
          $display("test %0s returned %0d data strobes instead of one",
                   test_name_i, strobe_cnt);
          err_cnt_o = err_cnt_o + 1;
        end
        wait_cnt   = 0;
        strobe_cnt = 0;
        addr_cnt   = 0;
        late_seen  = 1'b0;
      end
      ack_q = ap_ack_i;
      if (wait_cnt > 20 && !late_seen) begin
        $display("test %0s has waited more than 20 cycles for its acknowledge", test_name_i);
        err_cnt_o = err_cnt_o + 1;
        late_seen = 1'b1;
      end
    end
  end

endmodule

// File: tb/ap_properties.sv
/*
 * Bus and acknowledge properties
 * Bound to the memory access port top level
 */
`timescale 1ns/100ps

module ap_properties (
  input logic        dclk,
  input logic        apreset_n,
  input logic        device_en_i,
  input logic        dp_req_i,
  input logic        ap_ack_i,
  input logic [31:0] slv_addr_i,
  input logic [1:0]  slv_size_i,
  input logic [1:0]  slv_trans_i
);
  import ap_pkg::*;

  // Size code 3 is reserved
  assert property (@(posedge dclk) disable iff (!apreset_n) slv_size_i != 2'b11)
    else $error("bus size 3 issued");

  // Alignment during the address phase
  assert property (@(posedge dclk) disable iff (!apreset_n)
    (slv_trans_i == 2'b10 && slv_size_i == SIZE_WORD) |-> slv_addr_i[1:0] == 2'b00)
    else $error("word transfer not aligned");
  assert property (@(posedge dclk) disable iff (!apreset_n)
    (slv_trans_i == 2'b10 && slv_size_i == SIZE_HALF) |-> slv_addr_i[0] == 1'b0)
    else $error("halfword transfer not aligned");

  assert property (@(posedge dclk) disable iff (!apreset_n)
    !device_en_i |-> slv_trans_i == 2'b00)
    else $error("bus transfer while device disabled");

  // Acknowledge only closes a pending request
  assert property (@(posedge dclk) disable iff (!apreset_n)
    (ap_ack_i != $past(ap_ack_i)) |-> $past(dp_req_i != ap_ack_i))
    else $error("acknowledge toggled without a request");

endmodule

// File: tb/ap_tb.sv
/*
 * Memory access port testbench
 * Reads request vectors, drives the toggle handshake, models a bus
 * slave with random wait states and bounds the run with a timeout
 */
`timescale 1ns/100ps

module ap_tb;
  import ap_pkg::*;

  localparam int MAX_VEC = 64;

  logic        dclk;
  logic        apreset_n;
  logic        device_en_i;
  logic        dp_req_i;
  logic        dp_rnw_i;
  logic [3:0]  dp_regaddr_i;
  logic [31:0] dp_wdata_i;
  logic        ap_ack_o;
  logic        ap_wr_en_o;
  logic [31:0] ap_rdata_o;
  logic        ap_err_o;
  logic [31:0] slv_addr_o;
  logic [1:0]  slv_size_o;
  logic        slv_write_o;
  logic [1:0]  slv_trans_o;
  logic [31:0] slv_rdata_i;
  logic        slv_ready_i;
  logic        slv_resp_i;

  // Vector table
  logic [8*16-1:0] name_a  [0:MAX_VEC-1];
  logic [31:0]     en_a    [0:MAX_VEC-1];
  logic [31:0]     rnw_a   [0:MAX_VEC-1];
  logic [31:0]     reg_a   [0:MAX_VEC-1];
  logic [31:0]     wdata_a [0:MAX_VEC-1];
  logic [31:0]     resp_a  [0:MAX_VEC-1];
  logic [31:0]     rdata_a [0:MAX_VEC-1];
  logic [31:0]     err_a   [0:MAX_VEC-1];
  logic [31:0]     addr_a  [0:MAX_VEC-1];
  logic [31:0]     size_a  [0:MAX_VEC-1];
  integer          nvec;
  logic            loaded;

  // Expected values of the request in flight
  logic [8*16-1:0] cur_name;
  logic [31:0]     cur_rdata;
  logic            cur_err;
  logic [31:0]     cur_addr;
  logic [1:0]      cur_size;
  logic            cur_write;
  logic            cur_bus;
  logic            cur_chk_rd;
  logic            cur_resp;

  integer          err_cnt;
  integer          chk_cnt;
  integer          seed;
  integer          fd;
  integer          cnt;
  integer          idx;
  integer          cyc;
  integer          limit;
  logic [8*160-1:0] line;
  logic [31:0]     hold_rdata;

  ap_mem_access_port #(
    .BASE_ADDR (32'hE00FF003),
    .IDR_VALUE (32'h04770021)
  ) UUT (
    .dclk (dclk), .apreset_n (apreset_n), .device_en_i (device_en_i),
    .dp_req_i (dp_req_i), .dp_rnw_i (dp_rnw_i), .dp_regaddr_i (dp_regaddr_i),
    .dp_wdata_i (dp_wdata_i), .ap_ack_o (ap_ack_o), .ap_wr_en_o (ap_wr_en_o),
    .ap_rdata_o (ap_rdata_o), .ap_err_o (ap_err_o), .slv_addr_o (slv_addr_o),
    .slv_size_o (slv_size_o), .slv_write_o (slv_write_o), .slv_trans_o (slv_trans_o),
    .slv_rdata_i (slv_rdata_i), .slv_ready_i (slv_ready_i), .slv_resp_i (slv_resp_i)
  );

  ap_checker u_checker (
    .dclk (dclk), .apreset_n (apreset_n), .test_name_i (cur_name),
    .exp_rdata_i (cur_rdata), .exp_err_i (cur_err), .exp_addr_i (cur_addr),
    .exp_size_i (cur_size), .exp_write_i (cur_write), .exp_bus_i (cur_bus),
    .chk_rdata_i (cur_chk_rd), .dp_req_i (dp_req_i), .ap_ack_i (ap_ack_o),
    .ap_wr_en_i (ap_wr_en_o), .ap_rdata_i (ap_rdata_o), .ap_err_i (ap_err_o),
    .slv_addr_i (slv_addr_o), .slv_size_i (slv_size_o), .slv_write_i (slv_write_o),
    .slv_trans_i (slv_trans_o), .slv_ready_i (slv_ready_i),
    .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt)
  );

  bind ap_mem_access_port ap_properties u_props (
    .dclk (dclk), .apreset_n (apreset_n), .device_en_i (device_en_i),
    .dp_req_i (dp_req_i), .ap_ack_i (ap_ack_o), .slv_addr_i (slv_addr_o),
    .slv_size_i (slv_size_o), .slv_trans_i (slv_trans_o)
  );

  // ----------------------------------------------------------
  // Clock and vector load
  // ----------------------------------------------------------
  initial begin
    dclk = 1'b0;
    forever #5 dclk = ~dclk;
  end

  initial begin
    loaded = 1'b0;
    nvec   = 0;
    fd = $fopen("tb/ap_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file tb/ap_vectors.txt");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      while (!$feof(fd) && nvec < MAX_VEC) begin
        cnt = $fgets(line, fd);
        if (cnt > 0) begin
          // Comment and blank lines do not match all ten columns
          cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h",
                        name_a[nvec], en_a[nvec], rnw_a[nvec], reg_a[nvec],
                        wdata_a[nvec], resp_a[nvec], rdata_a[nvec], err_a[nvec],
                        addr_a[nvec], size_a[nvec]);
          if (cnt == 10) begin
            nvec = nvec + 1;
          end
        end
      end
      $fclose(fd);
      limit  = nvec * 20 + 50;
      loaded = 1'b1;
    end
  end

  // Cycle budget for the whole run
  initial begin
    cyc = 0;
    wait (loaded);
    while (cyc <= limit) begin
      @(posedge dclk);
      cyc = cyc + 1;
    end
    $display("timeout after %0d cycles, the DUT stopped answering", cyc);
    $display("CHECKS FAILED");
    $finish;
  end

  // ----------------------------------------------------------
  // Bus slave model
  // ----------------------------------------------------------
  task automatic stall_phase;
    integer n;
    n = {$random(seed)} % 4;
    if (n > 0) begin
      slv_ready_i = 1'b0;
      repeat (n) begin
        @(posedge dclk);
        #1;
      end
      slv_ready_i = 1'b1;
    end
    // Phase ends at this edge
    @(posedge dclk);
    #1;
  endtask

  initial begin
    seed        = 32'h8883aa93;
    slv_ready_i = 1'b1;
    slv_rdata_i = '0;
    slv_resp_i  = 1'b0;
    forever begin
      @(posedge dclk);
      #1;
      if (slv_trans_o == 2'b10) begin
        // Memory content is the address with its halves swapped
        hold_rdata = {slv_addr_o[15:0], slv_addr_o[31:16]};
        stall_phase();
        slv_rdata_i = slv_write_o ? '0 : hold_rdata;
        slv_resp_i  = cur_resp;
        stall_phase();
        slv_rdata_i = '0;
        slv_resp_i  = 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // Request driver
  // ----------------------------------------------------------
  initial begin
    apreset_n    = 1'b0;
    device_en_i  = 1'b1;
    dp_req_i     = 1'b0;
    dp_rnw_i     = 1'b1;
    dp_regaddr_i = '0;
    dp_wdata_i   = '0;
    cur_name     = "reset";
    cur_rdata    = '0;
    cur_err      = 1'b0;
    cur_addr     = '0;
    cur_size     = '0;
    cur_write    = 1'b0;
    cur_bus      = 1'b0;
    cur_chk_rd   = 1'b0;
    cur_resp     = 1'b0;
    repeat (5) @(posedge dclk);
    #1;
    apreset_n = 1'b1;
    wait (loaded);
    for (idx = 0; idx < nvec; idx = idx + 1) begin
      @(posedge dclk);
      #1;
      device_en_i  = en_a[idx][0];
      dp_rnw_i     = rnw_a[idx][0];
      dp_regaddr_i = reg_a[idx][3:0];
      dp_wdata_i   = wdata_a[idx];
      cur_name     = name_a[idx];
      cur_rdata    = rdata_a[idx];
      cur_err      = err_a[idx][0];
      cur_addr     = addr_a[idx];
      cur_size     = size_a[idx][1:0];
      cur_write    = ~rnw_a[idx][0];
      cur_resp     = resp_a[idx][0];
      // DRW and the banked group reach the bus only when enabled
      cur_bus      = en_a[idx][0] &&
                     (reg_a[idx][3:0] == REG_DRW ||
                      (reg_a[idx][3:0] >= REG_BD0 && reg_a[idx][3:0] <= REG_BD3));
      // Read data only means something on an error-free read
      cur_chk_rd   = rnw_a[idx][0] & ~err_a[idx][0];
      dp_req_i     = ~dp_req_i;
      while (dp_req_i != ap_ack_o) @(posedge dclk);
    end
    repeat (3) @(posedge dclk);
    $display("checks=%0d errors=%0d", chk_cnt, err_cnt);
    if (err_cnt == 0 && chk_cnt > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: tb/ap_vectors.txt
# name en rnw reg wdata resp exp_rdata exp_err exp_addr exp_size (all hex but name)
# read data is checked on error-free reads only, address and size on bus accesses only
rd_csw_rst   1 1 0 00000000 0 03000040 0 00000000 0
rd_tar_rst   1 1 1 00000000 0 ffffffff 0 00000000 0
rd_cfg       1 1 d 00000000 0 00000000 0 00000000 0
rd_base      1 1 e 00000000 0 e00ff003 0 00000000 0
rd_idr       1 1 f 00000000 0 04770021 0 00000000 0
rd_rsvd      1 1 9 00000000 0 00000000 0 00000000 0
wr_csw_legal 1 0 0 00000027 0 00000000 0 00000000 0
rd_csw_legal 1 1 0 00000000 0 03000042 0 00000000 0
wr_csw_word  1 0 0 00000012 0 00000000 0 00000000 0
wr_tar_wrap  1 0 1 200003f8 0 00000000 0 00000000 0
drw_wr_word  1 0 3 cafef00d 0 00000000 0 200003f8 2
drw_rd_word  1 1 3 00000000 0 03fc2000 0 200003fc 2
rd_tar_wrap  1 1 1 00000000 0 20000000 0 00000000 0
wr_csw_half  1 0 0 00000011 0 00000000 0 00000000 0
wr_tar_half  1 0 1 40001003 0 00000000 0 00000000 0
drw_rd_half  1 1 3 00000000 0 10024000 0 40001002 1
rd_tar_half  1 1 1 00000000 0 40001005 0 00000000 0
wr_csw_byte  1 0 0 00000010 0 00000000 0 00000000 0
drw_wr_byte  1 0 3 000000a5 0 00000000 0 40001005 0
drw_rd_err   1 1 3 00000000 1 00000000 1 40001006 0
rd_tar_err   1 1 1 00000000 0 40001006 0 00000000 0
wr_csw_bdx   1 0 0 00000012 0 00000000 0 00000000 0
wr_tar_bdx   1 0 1 30000010 0 00000000 0 00000000 0
bd2_rd       1 1 6 00000000 0 00183000 0 30000018 2
bd1_wr       1 0 5 12345678 0 00000000 0 30000014 2
rd_tar_bdx   1 1 1 00000000 0 30000010 0 00000000 0
drw_rd_off   0 1 3 00000000 0 00000000 1 00000000 0
drw_wr_off   0 0 3 deadbeef 0 00000000 1 00000000 0
rd_csw_off   0 1 0 00000000 0 03000012 0 00000000 0
rd_tar_off   1 1 1 00000000 0 30000010 0 00000000 0

// File: verilog/ap_addr_regs.sv
/*
 * CSW and TAR register file
 * Stores control and address state, applies wrapped auto-increment
 * and forms the aligned bus address and transfer size
 */
`timescale 1ns/100ps

module ap_addr_regs (
  input  logic                         dclk,
  input  logic                         apreset_n,
  input  logic                         done_wr_i,
  input  logic                         data_beat_i,
  input  logic                         is_csw_i,
  input  logic                         is_tar_i,
  input  logic                         is_drw_i,
  input  logic                         is_bdx_i,
  input  logic [ap_pkg::REGADDR_W-1:0] dp_regaddr_i,
  input  ap_pkg::ap_wdata_u            dp_wdata_i,
  input  logic [1:0]                   csw_size_wr_i,
  input  logic                         csw_inc_wr_i,
  input  logic                         slv_resp_i,
  input  logic                         device_en_i,
  output logic [ap_pkg::DATA_W-1:0]    csw_word_o,
  output logic [ap_pkg::DATA_W-1:0]    tar_o,
  output logic [ap_pkg::DATA_W-1:0]    slv_addr_o,
  output logic [1:0]                   slv_size_o
);
  import ap_pkg::*;

  logic [1:0]        csw_size_q;
  logic              csw_inc_q;
  logic [DATA_W-1:0] tar_q;
  logic              tar_inc;
  logic [2:0]        tar_inc_amt;
  logic [WRAP_W-1:0] tar_wrap;
  logic [1:0]        addr_lo_mask;

  // Increment after an error-free DRW beat only, BDx leaves TAR alone
  assign tar_inc = csw_inc_q & data_beat_i & is_drw_i & ~slv_resp_i;

  // Byte 1, half 2, word 4
  assign tar_inc_amt = {csw_size_q, ~|csw_size_q};
  // Carry out of the window is dropped
  assign tar_wrap = tar_q[WRAP_W-1:0] + WRAP_W'(tar_inc_amt);

  always_ff @(posedge dclk or negedge apreset_n) begin
    if (!apreset_n) begin
      csw_size_q <= SIZE_BYTE;
      csw_inc_q  <= 1'b0;
      tar_q      <= '1;
    end else begin
      if (done_wr_i && is_csw_i) begin
        csw_size_q <= csw_size_wr_i;
        csw_inc_q  <= csw_inc_wr_i;
      end
      if (tar_inc) begin
        tar_q <= {tar_q[DATA_W-1:WRAP_W], tar_wrap};
      end else if (done_wr_i && is_tar_i) begin
        tar_q <= dp_wdata_i.addr;
      end
    end
  end

  // ----------------------------------------------------------
  // Bus address and size
  // ----------------------------------------------------------
  // BDx is always a word transfer
  assign slv_size_o = is_bdx_i ? SIZE_WORD : csw_size_q;
  // Clear low bits to the size alignment
  assign addr_lo_mask = {~slv_size_o[1], ~|slv_size_o};
  assign slv_addr_o = {tar_q[DATA_W-1:4],
                       is_bdx_i ? dp_regaddr_i[1:0] : tar_q[3:2],
                       tar_q[1:0] & addr_lo_mask};

  // Prot 25:24 fixed, device enable in bit 6
  assign csw_word_o = {6'b0, 2'b11, 17'b0, device_en_i, 1'b0, csw_inc_q, 2'b0, csw_size_q};
  assign tar_o      = tar_q;

endmodule

// File: verilog/ap_mem_access_port.sv
/*
 * Debug memory access port
 * Turns toggle-handshake debug requests into register accesses
 * and single transfers on the system bus
 */
`timescale 1ns/100ps

module ap_mem_access_port #(
  parameter logic [31:0] BASE_ADDR = 32'h0000_0000,
  parameter logic [31:0] IDR_VALUE = 32'h0000_0000
) (
  input  logic                         dclk,
  input  logic                         apreset_n,
  input  logic                         device_en_i,
  // Debug port side
  input  logic                         dp_req_i,
  input  logic                         dp_rnw_i,
  input  logic [ap_pkg::REGADDR_W-1:0] dp_regaddr_i,
  input  logic [ap_pkg::DATA_W-1:0]    dp_wdata_i,
  output logic                         ap_ack_o,
  output logic                         ap_wr_en_o,
  output logic [ap_pkg::DATA_W-1:0]    ap_rdata_o,
  output logic                         ap_err_o,
  // System bus side
  output logic [ap_pkg::DATA_W-1:0]    slv_addr_o,
  output logic [1:0]                   slv_size_o,
  output logic                         slv_write_o,
  output logic [1:0]                   slv_trans_o,
  input  logic [ap_pkg::DATA_W-1:0]    slv_rdata_i,
  input  logic                         slv_ready_i,
  input  logic                         slv_resp_i
);
  import ap_pkg::*;

  logic              is_csw, is_tar, is_drw, is_bdx, bus_access;
  logic [1:0]        csw_size_wr;
  logic              csw_inc_wr;
  logic              done_wr, data_beat, suppressed;
  logic [DATA_W-1:0] csw_word, tar;

  // ----------------------------------------------------------
  // Decode
  // ----------------------------------------------------------
  ap_reg_decode u_decode (
    .dp_regaddr_i (dp_regaddr_i), .dp_wdata_i (dp_wdata_i),
    .is_csw_o (is_csw), .is_tar_o (is_tar), .is_drw_o (is_drw), .is_bdx_o (is_bdx),
    .bus_access_o (bus_access), .csw_size_wr_o (csw_size_wr), .csw_inc_wr_o (csw_inc_wr)
  );

  // ----------------------------------------------------------
  // Execute
  // ----------------------------------------------------------
  ap_xfer_fsm u_fsm (
    .dclk (dclk), .apreset_n (apreset_n), .device_en_i (device_en_i),
    .dp_req_i (dp_req_i), .dp_rnw_i (dp_rnw_i), .bus_access_i (bus_access),
    .slv_ready_i (slv_ready_i), .ap_ack_o (ap_ack_o), .done_wr_o (done_wr),
    .data_beat_o (data_beat), .suppressed_o (suppressed), .ap_wr_en_o (ap_wr_en_o),
    .slv_trans_o (slv_trans_o), .slv_write_o (slv_write_o)
  );

  ap_addr_regs u_regs (
    .dclk (dclk), .apreset_n (apreset_n), .done_wr_i (done_wr), .data_beat_i (data_beat),
    .is_csw_i (is_csw), .is_tar_i (is_tar), .is_drw_i (is_drw), .is_bdx_i (is_bdx),
    .dp_regaddr_i (dp_regaddr_i), .dp_wdata_i (dp_wdata_i),
    .csw_size_wr_i (csw_size_wr), .csw_inc_wr_i (csw_inc_wr), .slv_resp_i (slv_resp_i),
    .device_en_i (device_en_i), .csw_word_o (csw_word), .tar_o (tar),
    .slv_addr_o (slv_addr_o), .slv_size_o (slv_size_o)
  );

  // ----------------------------------------------------------
  // Result
  // ----------------------------------------------------------
  ap_read_mux #(.BASE_ADDR (BASE_ADDR), .IDR_VALUE (IDR_VALUE)) u_rmux (
    .dp_regaddr_i (dp_regaddr_i), .dp_rnw_i (dp_rnw_i), .csw_word_i (csw_word),
    .tar_i (tar), .slv_rdata_i (slv_rdata_i), .slv_resp_i (slv_resp_i),
    .suppressed_i (suppressed), .ap_rdata_o (ap_rdata_o), .ap_err_o (ap_err_o)
  );

endmodule

// File: verilog/ap_pkg.sv
/*
 * Memory access port shared definitions
 * Register codes, FSM state codes, transfer sizes and the write-data
 * union that is decoded either as CSW fields or as a raw address
 */

package ap_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int DATA_W    = 32;
  localparam int REGADDR_W = 4;
  // TAR bits touched by auto-increment
  localparam int WRAP_W    = 10;

  // ----------------------------------------------------------
  // Register address codes
  // ----------------------------------------------------------
  localparam logic [REGADDR_W-1:0] REG_CSW  = 4'd0;
  localparam logic [REGADDR_W-1:0] REG_TAR  = 4'd1;
  localparam logic [REGADDR_W-1:0] REG_DRW  = 4'd3;
  // Banked data registers live in bank 1
  localparam logic [REGADDR_W-1:0] REG_BD0  = 4'd4;
  localparam logic [REGADDR_W-1:0] REG_BD1  = 4'd5;
  localparam logic [REGADDR_W-1:0] REG_BD2  = 4'd6;
  localparam logic [REGADDR_W-1:0] REG_BD3  = 4'd7;
  localparam logic [REGADDR_W-1:0] REG_CFG  = 4'd13;
  localparam logic [REGADDR_W-1:0] REG_BASE = 4'd14;
  localparam logic [REGADDR_W-1:0] REG_IDR  = 4'd15;

  // Transfer FSM states
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_ADDR = 2'd1;
  localparam logic [1:0] ST_DATA = 2'd2;
  localparam logic [1:0] ST_DONE = 2'd3;

  // Bus transfer sizes, code 3 is never issued
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  // CFG register, little endian and no large data
  localparam logic [DATA_W-1:0] CFG_VAL = 32'h0000_0000;

  // CSW field layout as written by the debug port
  typedef struct packed {
    logic [25:0] rsvd_hi;
    logic [1:0]  addr_inc;
    logic        rsvd3;
    logic [2:0]  size;
  } csw_fields_t;

  // One write-data word, two views
  typedef union packed {
    csw_fields_t         csw;
    logic [DATA_W-1:0]   addr;
  } ap_wdata_u;

endpackage

// File: verilog/ap_read_mux.sv
/*
 * Read data and error formation
 * Selects the word returned to the debug port and the error flag
 */
`timescale 1ns/100ps

module ap_read_mux #(
  parameter logic [31:0] BASE_ADDR = 32'h0000_0000,
  parameter logic [31:0] IDR_VALUE = 32'h0000_0000
) (
  input  logic [ap_pkg::REGADDR_W-1:0] dp_regaddr_i,
  input  logic                         dp_rnw_i,
  input  logic [ap_pkg::DATA_W-1:0]    csw_word_i,
  input  logic [ap_pkg::DATA_W-1:0]    tar_i,
  input  logic [ap_pkg::DATA_W-1:0]    slv_rdata_i,
  input  logic                         slv_resp_i,
  input  logic                         suppressed_i,
  output logic [ap_pkg::DATA_W-1:0]    ap_rdata_o,
  output logic                         ap_err_o
);
  import ap_pkg::*;

  logic [REGADDR_W-1:0] sel_addr;

  // Writes map to the upper bank so bus data and TAR stay hidden
  assign sel_addr = {dp_regaddr_i[3] | ~dp_rnw_i, dp_regaddr_i[2:0]};

  always_comb begin
    case (sel_addr)
      REG_CSW:  ap_rdata_o = csw_word_i;
      REG_TAR:  ap_rdata_o = tar_i;
      REG_CFG:  ap_rdata_o = CFG_VAL;
      // ROM table pointer, format bit set
      REG_BASE: ap_rdata_o = {BASE_ADDR[31:12], 11'h001, BASE_ADDR[0]};
      REG_IDR:  ap_rdata_o = IDR_VALUE;
      REG_DRW, REG_BD0, REG_BD1, REG_BD2, REG_BD3: begin
        ap_rdata_o = slv_rdata_i;
      end
      // Reserved codes read as zero
      default:  ap_rdata_o = '0;
    endcase
  end

  // Bus error or refused transfer
  assign ap_err_o = slv_resp_i | suppressed_i;

endmodule

// File: verilog/ap_reg_decode.sv
/*
 * Register decode
 * Classifies the debug register address and legalises CSW write fields
 */
`timescale 1ns/100ps

module ap_reg_decode (
  input  logic [ap_pkg::REGADDR_W-1:0] dp_regaddr_i,
  input  ap_pkg::ap_wdata_u            dp_wdata_i,
  output logic                         is_csw_o,
  output logic                         is_tar_o,
  output logic                         is_drw_o,
  output logic                         is_bdx_o,
  output logic                         bus_access_o,
  output logic [1:0]                   csw_size_wr_o,
  output logic                         csw_inc_wr_o
);
  import ap_pkg::*;

  // ----------------------------------------------------------
  // Access classes
  // ----------------------------------------------------------
  assign is_csw_o = (dp_regaddr_i == REG_CSW);
  assign is_tar_o = (dp_regaddr_i == REG_TAR);
  assign is_drw_o = (dp_regaddr_i == REG_DRW);
  // Whole of bank 1 is BD0..BD3
  assign is_bdx_o = (dp_regaddr_i[3:2] == REG_BD0[3:2]);

  // DRW and BDx turn into a bus transfer
  assign bus_access_o = is_drw_o | is_bdx_o;

  // ----------------------------------------------------------
  // CSW write legalisation
  // ----------------------------------------------------------
  // Reserved size 3 is stored as word, bit 2 of the field is ignored
  assign csw_size_wr_o = (dp_wdata_i.csw.size[1:0] == 2'b11) ?
                         SIZE_WORD : dp_wdata_i.csw.size[1:0];

  // Packed transfer encoding dropped, only single increment kept
  assign csw_inc_wr_o = dp_wdata_i.csw.addr_inc[0];

endmodule

// File: verilog/ap_xfer_fsm.sv
/*
 * Transfer controller
 * Four-state FSM that sequences register and bus accesses,
 * owns the acknowledge level and drives the bus control strobes
 */
`timescale 1ns/100ps

module ap_xfer_fsm (
  input  logic       dclk,
  input  logic       apreset_n,
  input  logic       device_en_i,
  input  logic       dp_req_i,
  input  logic       dp_rnw_i,
  input  logic       bus_access_i,
  input  logic       slv_ready_i,
  output logic       ap_ack_o,
  output logic       done_wr_o,
  output logic       data_beat_o,
  output logic       suppressed_o,
  output logic       ap_wr_en_o,
  output logic [1:0] slv_trans_o,
  output logic       slv_write_o
);
  import ap_pkg::*;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic       active;

  // Request pending while the two levels differ
  assign active = dp_req_i ^ ap_ack_o;

  // ----------------------------------------------------------
  // State sequencing
  // ----------------------------------------------------------
  always_comb begin
    case (state_q)
      // Bus access only with device enabled, all else straight to DONE
      ST_IDLE: state_d = !active ? ST_IDLE :
                         (bus_access_i && device_en_i) ? ST_ADDR : ST_DONE;
      // Address phase may be stalled by the bus
      ST_ADDR: state_d = slv_ready_i ? ST_DATA : ST_ADDR;
      // Data phase ends on ready
      ST_DATA: state_d = slv_ready_i ? ST_DONE : ST_DATA;
      // Single cycle, ack toggles on the way out
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge dclk or negedge apreset_n) begin
    if (!apreset_n) begin
      state_q  <= ST_IDLE;
      ap_ack_o <= 1'b0;
    end else begin
      state_q <= state_d;
      // Toggle acknowledge to close the request
      if (state_q == ST_DONE) begin
        ap_ack_o <= ~ap_ack_o;
      end
    end
  end

  // ----------------------------------------------------------
  // Qualifiers for the register file and read path
  // ----------------------------------------------------------
  // Register writes land in DONE
  assign done_wr_o   = (state_q == ST_DONE) & ~dp_rnw_i;
  // Last cycle of a data phase
  assign data_beat_o = (state_q == ST_DATA) & slv_ready_i;
  // Bus access refused while device disabled
  assign suppressed_o = (state_q == ST_IDLE) & active & bus_access_i & ~device_en_i;

  // Return strobe: register DONE, bus data beat, or suppression
  assign ap_wr_en_o = ((state_q == ST_DONE) & ~bus_access_i) |
                      data_beat_o | suppressed_o;

  // ----------------------------------------------------------
  // Bus control
  // ----------------------------------------------------------
  // Non-sequential only during the address phase
  assign slv_trans_o = {(state_q == ST_ADDR), 1'b0};
  assign slv_write_o = ~dp_rnw_i;

endmodule
